//--- all.f
+incdir+tests
verilog/ahb_ic_pkg.sv
verilog/ahb_grant_fsm.sv
verilog/ahb_priority_rank.sv
verilog/ahb_request_mux.sv
verilog/ahb_response_router.sv
verilog/ahb_slave_port.sv
tests/tb_slave_port.sv

//--- run.sh
#!/bin/sh
# build and run the slave-port testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f all.f \
    --top-module tb_slave_port \
    -o tb_slave_port

./obj_dir/tb_slave_port

//--- tests/slave_port_cases.svh
/*
 * stimulus and expected owners for the slave-port testbench
 * - one row per clock cycle
 */
`ifndef SLAVE_PORT_CASES_SVH
`define SLAVE_PORT_CASES_SVH

// columns: hsel per master, slave hreadyout, slave hresp, slave hrdata,
// owner on grant_o after the clock edge
typedef struct packed {
    grant_vec_t  hsel;
    logic        rdy;
    logic        resp;
    logic [31:0] rdata;
    grant_vec_t  owner;
} case_t;

localparam int NUM_CASES = 28;

case_t cases [NUM_CASES];

task automatic fill_cases();
    cases[0]  = '{4'b0000, 1'b1, 1'b0, 32'h0000_0000, 4'b0000};
    // single request from master 2
    cases[1]  = '{4'b0100, 1'b1, 1'b0, 32'h1111_2222, 4'b0100};
    cases[2]  = '{4'b0100, 1'b1, 1'b0, 32'h3333_4444, 4'b0100};
    cases[3]  = '{4'b0000, 1'b1, 1'b0, 32'h5555_6666, 4'b0000};
    // everybody at once, master 0 still holds rank 0
    cases[4]  = '{4'b1111, 1'b1, 1'b0, 32'h7777_8888, 4'b0001};
    cases[5]  = '{4'b1111, 1'b1, 1'b1, 32'h9999_aaaa, 4'b0001};
    // back-pressure from the slave
    cases[6]  = '{4'b1111, 1'b0, 1'b0, 32'hbbbb_cccc, 4'b0001};
    cases[7]  = '{4'b1111, 1'b0, 1'b0, 32'hdddd_eeee, 4'b0001};
    cases[8]  = '{4'b1110, 1'b1, 1'b0, 32'h0f0f_0f0f, 4'b0000};
    cases[9]  = '{4'b1110, 1'b1, 1'b0, 32'hf0f0_f0f0, 4'b0010};
    cases[10] = '{4'b1111, 1'b1, 1'b0, 32'h1234_5678, 4'b0010};
    cases[11] = '{4'b1101, 1'b1, 1'b0, 32'h9abc_def0, 4'b0000};
    cases[12] = '{4'b1111, 1'b1, 1'b0, 32'h0bad_cafe, 4'b1000};
    cases[13] = '{4'b0111, 1'b1, 1'b1, 32'hfeed_face, 4'b0000};
    cases[14] = '{4'b0111, 1'b1, 1'b0, 32'hc0de_0001, 4'b0100};
    cases[15] = '{4'b0011, 1'b1, 1'b0, 32'hc0de_0002, 4'b0000};
    cases[16] = '{4'b0011, 1'b1, 1'b0, 32'hc0de_0003, 4'b0001};
    cases[17] = '{4'b0000, 1'b1, 1'b0, 32'hc0de_0004, 4'b0000};
    cases[18] = '{4'b0000, 1'b1, 1'b0, 32'hc0de_0005, 4'b0000};
    cases[19] = '{4'b1000, 1'b1, 1'b0, 32'ha5a5_5a5a, 4'b1000};
    cases[20] = '{4'b1000, 1'b0, 1'b1, 32'h5a5a_a5a5, 4'b1000};
    cases[21] = '{4'b1010, 1'b1, 1'b1, 32'h0123_4567, 4'b1000};
    cases[22] = '{4'b0010, 1'b1, 1'b0, 32'h89ab_cdef, 4'b0000};
    cases[23] = '{4'b0010, 1'b1, 1'b0, 32'h2468_ace0, 4'b0010};
    cases[24] = '{4'b0110, 1'b0, 1'b0, 32'h1357_9bdf, 4'b0010};
    cases[25] = '{4'b0100, 1'b1, 1'b0, 32'h4242_4242, 4'b0000};
    cases[26] = '{4'b0100, 1'b1, 1'b0, 32'h6464_6464, 4'b0100};
    cases[27] = '{4'b0000, 1'b1, 1'b0, 32'h8080_8080, 4'b0000};
endtask

`endif

//--- tests/tb_slave_port.sv
/*
 * testbench for the AHB-Lite slave-port stage
 * - clock, reset and watchdog
 * - rotating-rank reference model of the arbiter
 * - table-driven stimulus with checks on both bus sides
 */
`timescale 1ns/1ps

module tb_slave_port import ahb_ic_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 2;

    `include "slave_port_cases.svh"

    logic                           HCLK;
    logic                           HRESETn;
    ahb_req_t     [NUM_MASTERS-1:0] mst_req;
    ahb_mst_rsp_t [NUM_MASTERS-1:0] mst_rsp;
    ahb_slv_req_t                   slv_req;
    ahb_slv_rsp_t                   slv_rsp;
    grant_vec_t                     grant;

    // reference model of ranks and owner
    // owner is -1 while the bus is free
    int          model_rank [NUM_MASTERS];
    int          model_owner;
    logic        model_hready;
    grant_vec_t  exp_hreadyout;
    logic [31:0] lcg_state;

    ahb_slave_port ahb_slave_port_i (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .mst_req_i (mst_req),
        .mst_rsp_o (mst_rsp),
        .slv_req_o (slv_req),
        .slv_rsp_i (slv_rsp),
        .grant_o   (grant)
    );

    always #(CLK_PERIOD / 2) HCLK = ~HCLK;

    ////////////////////
    // helpers
    ////////////////////
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic grant_vec_t onehot(input int m);
        if (m < 0) begin
            return '0;
        end
        return grant_vec_t'(1) << m;
    endfunction

    task automatic report_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1, "check failed");
    endtask

    ////////////////////
    // rank model
    ////////////////////
    // a free bus goes to the lowest-ranked requester
    // an owner keeps the bus while its hsel stays high
    function automatic int choose_next(input grant_vec_t hsel);
        int best;
        best = -1;
        if (model_owner >= 0) begin
            return ((hsel & onehot(model_owner)) != '0) ? model_owner : -1;
        end
        for (int i = 0; i < NUM_MASTERS; i++) begin
            if (hsel[i] && (best < 0 || model_rank[i] < model_rank[best])) begin
                best = i;
            end
        end
        return best;
    endfunction

    task automatic rotate_ranks(input int win);
        int old;
        old = model_rank[win];
        for (int i = 0; i < NUM_MASTERS; i++) begin
            if (i == win) begin
                model_rank[i] = NUM_MASTERS - 1;
            end else if (model_rank[i] > old) begin
                model_rank[i] = model_rank[i] - 1;
            end
        end
    endtask

    task automatic update_model(input case_t c, input int next_owner);
        if (model_owner < 0 && next_owner >= 0) begin
            rotate_ranks(next_owner);
        end
        if (c.hsel == '0) begin
            exp_hreadyout = '1;
        end else begin
            exp_hreadyout = onehot(next_owner) & {NUM_MASTERS{c.rdy}};
        end
        if (next_owner >= 0) begin
            model_hready = mst_req[next_owner].hready;
        end
        model_owner = next_owner;
    endtask

    ////////////////////
    // stimulus and checks
    ////////////////////
    task automatic drive_row(input case_t c);
        for (int i = 0; i < NUM_MASTERS; i++) begin
            lcg_state = lcg_next(lcg_state);
            mst_req[i].hsel   = c.hsel[i];
            mst_req[i].htrans = c.hsel[i] ? NONSEQ : IDLE;
            mst_req[i].hwrite = lcg_state[31];
            mst_req[i].hsize  = lcg_state[29:27];
            mst_req[i].haddr  = lcg_state;
            mst_req[i].hready = lcg_state[30];
            lcg_state = lcg_next(lcg_state);
            mst_req[i].hwdata = lcg_state;
        end
        slv_rsp = '{hrdata: c.rdata, hreadyout: c.rdy, hresp: c.resp};
    endtask

    task automatic check_registered();
        assert (grant == onehot(model_owner)) else
            report_error($sformatf("grant_o %b, expected %b", grant, onehot(model_owner)));
        for (int i = 0; i < NUM_MASTERS; i++) begin
            assert (mst_rsp[i].hreadyout == exp_hreadyout[i]) else
                report_error($sformatf("master %0d hreadyout %b, expected %b",
                                       i, mst_rsp[i].hreadyout, exp_hreadyout[i]));
        end
    endtask

    task automatic check_comb(input case_t c, input int next_owner);
        int          src;
        logic        exp_hready;
        logic [31:0] exp_rdata;
        src        = (next_owner >= 0) ? next_owner : model_owner;
        exp_hready = model_hready;
        if (next_owner >= 0) begin
            exp_hready = mst_req[next_owner].hready;
        end
        if (src >= 0) begin
            assert (slv_req.htrans == mst_req[src].htrans
                    && slv_req.hwrite == mst_req[src].hwrite
                    && slv_req.hsize == mst_req[src].hsize
                    && slv_req.haddr == mst_req[src].haddr
                    && slv_req.hwdata == mst_req[src].hwdata) else
                report_error($sformatf("slave request does not follow master %0d", src));
        end else begin
            assert (slv_req.htrans == IDLE && slv_req.hwrite == 1'b0
                    && slv_req.hsize == 3'b000 && slv_req.haddr == '0
                    && slv_req.hwdata == '0) else
                report_error("slave request not IDLE with the bus free");
        end
        assert (slv_req.hready == exp_hready) else
            report_error($sformatf("slave hready %b, expected %b", slv_req.hready, exp_hready));
        for (int i = 0; i < NUM_MASTERS; i++) begin
            exp_rdata = (i == model_owner) ? c.rdata : 32'h0;
            assert (mst_rsp[i].hrdata == exp_rdata && mst_rsp[i].hresp == c.resp) else
                report_error($sformatf("master %0d hrdata %h hresp %b, expected %h %b",
                                       i, mst_rsp[i].hrdata, mst_rsp[i].hresp,
                                       exp_rdata, c.resp));
        end
    endtask

    initial begin
        int next_owner;
        HCLK          = 1'b0;
        HRESETn       = 1'b0;
        mst_req       = '0;
        slv_rsp       = '{hrdata: 32'h0, hreadyout: 1'b1, hresp: 1'b0};
        lcg_state     = 32'h0d06_628f;
        model_owner   = -1;
        model_hready  = 1'b1;
        exp_hreadyout = '1;
        for (int i = 0; i < NUM_MASTERS; i++) begin
            model_rank[i] = i;
        end
        fill_cases();
        repeat (RESET_CYCLES) @(negedge HCLK);
        HRESETn = 1'b1;
        #1;
        check_registered();
        assert (slv_req.htrans == IDLE) else
            report_error("slave htrans not IDLE after reset");
        for (int k = 0; k < NUM_CASES; k++) begin
            @(negedge HCLK);
            check_registered();
            drive_row(cases[k]);
            #1;
            next_owner = choose_next(cases[k].hsel);
            assert (onehot(next_owner) == cases[k].owner) else
                report_error($sformatf("row %0d owner disagrees with the rank model", k));
            check_comb(cases[k], next_owner);
            update_model(cases[k], next_owner);
        end
        @(negedge HCLK);
        check_registered();
        $display("STATUS: PASS");
        $finish;
    end

    // watchdog allows eight cycles per row plus the reset
    initial begin
        #(CLK_PERIOD * (NUM_CASES * 8 + RESET_CYCLES));
        $display("watchdog expired, the table did not finish in time");
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    end

endmodule

//--- verilog/ahb_grant_fsm.sv
/*
 * ownership state machine for the shared slave
 * - picks the lowest-ranked requester while the bus is free
 * - holds the registered one-hot grant while the owner keeps hsel
 */
`timescale 1ns/1ps

module ahb_grant_fsm import ahb_ic_pkg::*; (
    input  logic       HCLK,
    input  logic       HRESETn,
    input  grant_vec_t hsel_i,
    input  rank_vec_t  rank_i,
    output grant_vec_t next_grant_o,
    output grant_vec_t grant_o,
    output logic       rank_load_o
);

    arb_state_e        state_q;
    arb_state_e        state_d;
    grant_vec_t        grant_q;
    grant_vec_t        grant_d;
    grant_vec_t        pick;
    logic [RANK_W-1:0] best_rank;
    logic              found;

    ////////////////////
    // winner selection
    ////////////////////
    // ranks are a permutation, so at most one requester holds the best rank
    always_comb begin
        pick      = '0;
        best_rank = RANK_MAX;
        found     = 1'b0;
        for (int i = 0; i < NUM_MASTERS; i++) begin
            if (hsel_i[i] && (!found || rank_i[i] < best_rank)) begin
                pick      = grant_vec_t'(1) << i;
                best_rank = rank_i[i];
                found     = 1'b1;
            end
        end
    end

    ////////////////////
    // next state
    ////////////////////
    always_comb begin
        state_d     = state_q;
        grant_d     = grant_q;
        rank_load_o = 1'b0;
        case (state_q)
            ARB_IDLE: begin
                grant_d = pick;
                if (found) begin
                    state_d     = ARB_OWNED;
                    rank_load_o = 1'b1;
                end
            end
            ARB_OWNED: begin
                // release in the cycle the owner drops hsel, no new pick yet
                if (!(|(hsel_i & grant_q))) begin
                    grant_d = '0;
                    state_d = ARB_IDLE;
                end
            end
            default: begin
                grant_d = '0;
                state_d = ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            state_q <= ARB_IDLE;
            grant_q <= '0;
        end else begin
            state_q <= state_d;
            grant_q <= grant_d;
        end
    end

    assign next_grant_o = grant_d;
    assign grant_o      = grant_q;

endmodule

//--- verilog/ahb_ic_pkg.sv
/*
 * shared definitions for the AHB-Lite slave-port interconnect stage
 * - bus widths, master count and rank sizing
 * - transfer type and arbiter state encodings
 * - request and response structs for masters and the slave
 */
package ahb_ic_pkg;

    ////////////////////
    // sizing
    ////////////////////
    localparam int NUM_MASTERS = 4;
    localparam int RANK_W      = $clog2(NUM_MASTERS);
    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;

    // lowest priority rank, given to a master right after it wins
    localparam logic [RANK_W-1:0] RANK_MAX = RANK_W'(NUM_MASTERS - 1);

    ////////////////////
    // encodings
    ////////////////////
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    typedef enum logic {
        ARB_IDLE  = 1'b0,
        ARB_OWNED = 1'b1
    } arb_state_e;

    ////////////////////
    // bus structs
    ////////////////////
    // one master's request, 72 bits
    typedef struct packed {
        logic              hsel;
        htrans_e           htrans;
        logic              hwrite;
        logic [2:0]        hsize;
        logic [ADDR_W-1:0] haddr;
        logic [DATA_W-1:0] hwdata;
        logic              hready;
    } ahb_req_t;

    // address and control forwarded from the owner, before the hready loop
    typedef struct packed {
        htrans_e           htrans;
        logic              hwrite;
        logic [2:0]        hsize;
        logic [ADDR_W-1:0] haddr;
        logic [DATA_W-1:0] hwdata;
    } ahb_slv_addr_t;

    // request to the slave, 71 bits
    typedef struct packed {
        htrans_e           htrans;
        logic              hwrite;
        logic [2:0]        hsize;
        logic [ADDR_W-1:0] haddr;
        logic [DATA_W-1:0] hwdata;
        logic              hready;
    } ahb_slv_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] hrdata;
        logic              hreadyout;
        logic              hresp;
    } ahb_slv_rsp_t;

    typedef struct packed {
        logic [DATA_W-1:0] hrdata;
        logic              hreadyout;
        logic              hresp;
    } ahb_mst_rsp_t;

    // one-hot ownership and per-master ranks
    typedef logic [NUM_MASTERS-1:0]             grant_vec_t;
    typedef logic [NUM_MASTERS-1:0][RANK_W-1:0] rank_vec_t;

endpackage

//--- verilog/ahb_priority_rank.sv
/*
 * rotating priority ranks, one counter per master
 * - rank 0 is served first, master i starts at rank i
 * - a winner drops to the lowest rank, masters behind it move up
 */
`timescale 1ns/1ps

module ahb_priority_rank import ahb_ic_pkg::*; (
    input  logic       HCLK,
    input  logic       HRESETn,
    input  logic       rank_load_i,
    input  grant_vec_t winner_i,
    output rank_vec_t  rank_o
);

    rank_vec_t         rank_q;
    rank_vec_t         rank_d;
    logic [RANK_W-1:0] win_rank;

    ////////////////////
    // winner's old rank
    ////////////////////
    always_comb begin
        win_rank = '0;
        for (int i = 0; i < NUM_MASTERS; i++) begin
            if (winner_i[i]) begin
                win_rank = rank_q[i];
            end
        end
    end

    ////////////////////
    // rotation
    ////////////////////
    always_comb begin
        for (int i = 0; i < NUM_MASTERS; i++) begin
            if (winner_i[i]) begin
                rank_d[i] = RANK_MAX;
            end else if (rank_q[i] > win_rank) begin
                // count down towards rank 0
                rank_d[i] = rank_q[i] - 1'b1;
            end else begin
                rank_d[i] = rank_q[i];
            end
        end
    end

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            for (int i = 0; i < NUM_MASTERS; i++) begin
                rank_q[i] <= RANK_W'(i);
            end
        end else if (rank_load_i) begin
            rank_q <= rank_d;
        end
    end

    assign rank_o = rank_q;

endmodule

//--- verilog/ahb_request_mux.sv
/*
 * request multiplexer towards the slave
 * - forwards address and control of the next or current owner
 * - drives IDLE and zeros when nobody owns the bus
 */
`timescale 1ns/1ps

module ahb_request_mux import ahb_ic_pkg::*; (
    input  ahb_req_t [NUM_MASTERS-1:0] mst_req_i,
    input  grant_vec_t                 next_grant_i,
    input  grant_vec_t                 grant_i,
    output ahb_slv_addr_t              slv_addr_o
);

    grant_vec_t sel;

    // next_grant covers a fresh win, grant covers the release cycle
    assign sel = next_grant_i | grant_i;

    ////////////////////
    // one-hot select
    ////////////////////
    always_comb begin
        slv_addr_o = '{
            htrans: IDLE,
            hwrite: 1'b0,
            hsize:  '0,
            haddr:  '0,
            hwdata: '0
        };
        for (int i = 0; i < NUM_MASTERS; i++) begin
            if (sel[i]) begin
                slv_addr_o.htrans = mst_req_i[i].htrans;
                slv_addr_o.hwrite = mst_req_i[i].hwrite;
                slv_addr_o.hsize  = mst_req_i[i].hsize;
                slv_addr_o.haddr  = mst_req_i[i].haddr;
                slv_addr_o.hwdata = mst_req_i[i].hwdata;
            end
        end
    end

endmodule

//--- verilog/ahb_response_router.sv
/*
 * response routing back to the masters
 * - registered hreadyout per master
 * - read data only to the owner, hresp to all
 * - owner's hready looped to the slave, held while nobody is chosen
 */
`timescale 1ns/1ps

module ahb_response_router import ahb_ic_pkg::*; (
    input  logic                           HCLK,
    input  logic                           HRESETn,
    input  ahb_req_t     [NUM_MASTERS-1:0] mst_req_i,
    input  grant_vec_t                     next_grant_i,
    input  grant_vec_t                     grant_i,
    input  ahb_slv_rsp_t                   slv_rsp_i,
    output ahb_mst_rsp_t [NUM_MASTERS-1:0] mst_rsp_o,
    output logic                           slv_hready_o
);

    grant_vec_t hsel;
    grant_vec_t hreadyout_d;
    grant_vec_t hreadyout_q;
    logic       hready_sel;
    logic       hready_lat_q;

    ////////////////////
    // hreadyout
    ////////////////////
    // waiting masters are stalled until they become the next owner
    always_comb begin
        for (int i = 0; i < NUM_MASTERS; i++) begin
            hsel[i]        = mst_req_i[i].hsel;
            hreadyout_d[i] = next_grant_i[i] & slv_rsp_i.hreadyout;
        end
        if (!(|hsel)) begin
            hreadyout_d = '1;
        end
    end

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            hreadyout_q <= '1;
        end else begin
            hreadyout_q <= hreadyout_d;
        end
    end

    ////////////////////
    // hready loop
    ////////////////////
    always_comb begin
        hready_sel = hready_lat_q;
        for (int i = 0; i < NUM_MASTERS; i++) begin
            if (next_grant_i[i]) begin
                hready_sel = mst_req_i[i].hready;
            end
        end
    end

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            hready_lat_q <= 1'b1;
        end else begin
            hready_lat_q <= hready_sel;
        end
    end

    assign slv_hready_o = hready_sel;

    // read data gated to the current owner
    always_comb begin
        for (int i = 0; i < NUM_MASTERS; i++) begin
            mst_rsp_o[i].hrdata    = grant_i[i] ? slv_rsp_i.hrdata : '0;
            mst_rsp_o[i].hreadyout = hreadyout_q[i];
            mst_rsp_o[i].hresp     = slv_rsp_i.hresp;
        end
    end

endmodule

//--- verilog/ahb_slave_port.sv
/*
 * slave-port stage of the multi-master AHB-Lite interconnect
 * - joins the grant FSM, rank registers, request mux and response router
 */
`timescale 1ns/1ps

module ahb_slave_port import ahb_ic_pkg::*; (
    input  logic                           HCLK,
    input  logic                           HRESETn,
    input  ahb_req_t     [NUM_MASTERS-1:0] mst_req_i,
    output ahb_mst_rsp_t [NUM_MASTERS-1:0] mst_rsp_o,
    output ahb_slv_req_t                   slv_req_o,
    input  ahb_slv_rsp_t                   slv_rsp_i,
    output grant_vec_t                     grant_o
);

    grant_vec_t    hsel;
    grant_vec_t    next_grant;
    grant_vec_t    grant_q;
    rank_vec_t     rank_q;
    logic          rank_load;
    logic          slv_hready;
    ahb_slv_addr_t slv_addr;

    for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_hsel
        assign hsel[i] = mst_req_i[i].hsel;
    end

    ////////////////////
    // arbitration
    ////////////////////
    ahb_grant_fsm ahb_grant_fsm_i (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .hsel_i       (hsel),
        .rank_i       (rank_q),
        .next_grant_o (next_grant),
        .grant_o      (grant_q),
        .rank_load_o  (rank_load)
    );

    ahb_priority_rank ahb_priority_rank_i (
        .HCLK        (HCLK),
        .HRESETn     (HRESETn),
        .rank_load_i (rank_load),
        .winner_i    (next_grant),
        .rank_o      (rank_q)
    );

    ////////////////////
    // data paths
    ////////////////////
    ahb_request_mux ahb_request_mux_i (
        .mst_req_i    (mst_req_i),
        .next_grant_i (next_grant),
        .grant_i      (grant_q),
        .slv_addr_o   (slv_addr)
    );

    ahb_response_router ahb_response_router_i (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .mst_req_i    (mst_req_i),
        .next_grant_i (next_grant),
        .grant_i      (grant_q),
        .slv_rsp_i    (slv_rsp_i),
        .mst_rsp_o    (mst_rsp_o),
        .slv_hready_o (slv_hready)
    );

    assign slv_req_o = '{
        htrans: slv_addr.htrans,
        hwrite: slv_addr.hwrite,
        hsize:  slv_addr.hsize,
        haddr:  slv_addr.haddr,
        hwdata: slv_addr.hwdata,
        hready: slv_hready
    };

    assign grant_o = grant_q;

endmodule
